// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_idx_t;
	typedef logic [xlen-1:0] word_t;

	typedef enum logic [3:0] {
		cls_none,
		cls_lui,
		cls_auipc,
		cls_alu,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_load,
		cls_store
	} instr_class_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_xor,
		alu_or,
		alu_and,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu
	} alu_op_e;

	// encoded as the branch funct3
	typedef enum logic [2:0] {
		br_beq  = 3'b000,
		br_bne  = 3'b001,
		br_blt  = 3'b100,
		br_bge  = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} branch_cond_e;

	typedef struct packed {
		instr_class_e cls;
		alu_op_e alu_op;
		branch_cond_e branch_cond;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t imm;
		logic use_imm; // second operand is imm
		logic writes_rd; // rd written and nonzero
	} decoded_t;

	typedef struct packed {
		logic is_write;
		word_t addr;
		word_t wdata;
	} bus_cmd_t;

	typedef struct packed {
		word_t araddr;
		logic arvalid;
		logic rready;
	} rd_req_t;

	typedef struct packed {
		logic arready;
		word_t rdata;
		logic rvalid;
	} rd_rsp_t;

	typedef struct packed {
		word_t awaddr;
		logic awvalid;
		word_t wdata;
		logic wvalid;
		logic bready;
	} wr_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
	} wr_rsp_t;

endpackage

`default_nettype wire

// File: src/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input wire clk,
	input wire rstn,
	input wire rv_pkg::word_t instr,
	output rv_pkg::decoded_t dec
);
	import rv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic f7_zero;
	logic f7_alt;
	word_t imm_i;
	word_t imm_s;
	word_t imm_b;
	word_t imm_u;
	word_t imm_j;
	alu_op_e alu_sel;
	decoded_t nxt;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign f7_zero = funct7 == 7'b0000000;
	assign f7_alt = funct7 == 7'b0100000;

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'd0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// shared by op and op-imm, funct7[5] picks sub and sra
	always_comb begin
		case (funct3)
			3'b000: alu_sel = (opcode[5] && funct7[5]) ? alu_sub : alu_add;
			3'b001: alu_sel = alu_sll;
			3'b010: alu_sel = alu_slt;
			3'b011: alu_sel = alu_sltu;
			3'b100: alu_sel = alu_xor;
			3'b101: alu_sel = funct7[5] ? alu_sra : alu_srl;
			3'b110: alu_sel = alu_or;
			default: alu_sel = alu_and;
		endcase
	end

	always_comb begin
		nxt.cls = cls_none;
		nxt.alu_op = alu_sel;
		nxt.branch_cond = branch_cond_e'(funct3);
		nxt.rd = instr[11:7];
		nxt.rs1 = instr[19:15];
		nxt.rs2 = instr[24:20];
		nxt.imm = imm_i;
		nxt.use_imm = 1'b0;
		case (opcode)
			7'b0110111: begin
				nxt.cls = cls_lui;
				nxt.imm = imm_u;
			end
			7'b0010111: begin
				nxt.cls = cls_auipc;
				nxt.imm = imm_u;
			end
			7'b1101111: begin
				nxt.cls = cls_jal;
				nxt.imm = imm_j;
			end
			7'b1100111: if (funct3 == 3'b000) nxt.cls = cls_jalr;
			7'b1100011: begin
				nxt.imm = imm_b;
				if (funct3[2:1] != 2'b01) nxt.cls = cls_branch; // 010 and 011 unused
			end
			7'b0000011: begin
				nxt.use_imm = 1'b1;
				if (funct3 == 3'b010) nxt.cls = cls_load;
			end
			7'b0100011: begin
				nxt.imm = imm_s;
				nxt.use_imm = 1'b1;
				if (funct3 == 3'b010) nxt.cls = cls_store;
			end
			7'b0010011: begin
				nxt.use_imm = 1'b1;
				if (funct3 == 3'b001 ? f7_zero : funct3 == 3'b101 ? (f7_zero || f7_alt) : 1'b1)
					nxt.cls = cls_alu;
			end
			7'b0110011: begin
				if (f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))
					nxt.cls = cls_alu;
			end
			default: nxt.cls = cls_none;
		endcase
		nxt.writes_rd = (nxt.rd != '0) && (nxt.cls inside {cls_lui, cls_auipc, cls_alu,
			cls_jal, cls_jalr, cls_load});
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec <= '0;
		end else begin
			dec <= nxt;
		end
	end

endmodule

`default_nettype wire

// File: src/int_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module int_regfile (
	input wire clk,
	input wire rstn,
	input wire rv_pkg::reg_idx_t rs1,
	input wire rv_pkg::reg_idx_t rs2,
	output rv_pkg::word_t rs1_val,
	output rv_pkg::word_t rs2_val,
	input wire we,
	input wire rv_pkg::reg_idx_t rd,
	input wire rv_pkg::word_t rd_val
);
	import rv_pkg::*;

	word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rd != '0) begin
			regs[rd] <= rd_val;
		end
	end

	always_ff @(posedge clk) begin
		rs1_val <= (rs1 == '0) ? '0 : regs[rs1];
		rs2_val <= (rs2 == '0) ? '0 : regs[rs2];
	end

endmodule

`default_nettype wire

// File: src/int_alu.sv
`timescale 1ns/1ns
`default_nettype none

module int_alu (
	input wire clk,
	input wire rstn,
	input wire rv_pkg::decoded_t dec,
	input wire rv_pkg::word_t rs1_val,
	input wire rv_pkg::word_t rs2_val,
	output rv_pkg::word_t result,
	output logic taken
);
	import rv_pkg::*;

	word_t op_b;
	word_t res;
	logic [4:0] shamt;
	logic cond;

	assign op_b = dec.use_imm ? dec.imm : rs2_val;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec.alu_op)
			alu_add: res = rs1_val + op_b;
			alu_sub: res = rs1_val - op_b;
			alu_xor: res = rs1_val ^ op_b;
			alu_or: res = rs1_val | op_b;
			alu_and: res = rs1_val & op_b;
			alu_sll: res = rs1_val << shamt;
			alu_srl: res = rs1_val >> shamt;
			alu_sra: res = word_t'($signed(rs1_val) >>> shamt);
			alu_slt: res = {31'd0, $signed(rs1_val) < $signed(op_b)};
			alu_sltu: res = {31'd0, rs1_val < op_b};
			default: res = '0;
		endcase
	end

	// branches always compare the two registers
	always_comb begin
		case (dec.branch_cond)
			br_beq: cond = rs1_val == rs2_val;
			br_bne: cond = rs1_val != rs2_val;
			br_blt: cond = $signed(rs1_val) < $signed(rs2_val);
			br_bge: cond = $signed(rs1_val) >= $signed(rs2_val);
			br_bltu: cond = rs1_val < rs2_val;
			br_bgeu: cond = rs1_val >= rs2_val;
			default: cond = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		result <= res;
		if (!rstn) begin
			taken <= 1'b0;
		end else begin
			taken <= (dec.cls == cls_branch) && cond;
		end
	end

endmodule

`default_nettype wire

// File: src/core_control.sv
`timescale 1ns/1ns
`default_nettype none

module core_control #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input wire clk,
	input wire rstn,
	output rv_pkg::word_t instr,
	input wire rv_pkg::decoded_t dec,
	input wire rv_pkg::word_t rs1_val,
	input wire rv_pkg::word_t rs2_val,
	input wire rv_pkg::word_t alu_result,
	input wire taken,
	output rv_pkg::bus_cmd_t cmd,
	output logic start,
	input wire done,
	input wire rv_pkg::word_t rdata,
	output logic we,
	output rv_pkg::reg_idx_t rd,
	output rv_pkg::word_t rd_val
);
	import rv_pkg::*;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_read,
		st_exec,
		st_mem,
		st_write
	} state_e;

	state_e state;
	word_t pc;
	word_t pc_next;
	word_t pc_plus4;
	word_t pc_target;
	word_t data_addr;
	logic busy; // a bus transfer is running
	logic is_mem;

	assign pc_plus4 = pc + 32'd4;
	assign pc_target = pc + dec.imm;
	assign data_addr = rs1_val + dec.imm;
	assign is_mem = (dec.cls == cls_load) || (dec.cls == cls_store);

	assign cmd = '{
		is_write: (state == st_mem) && (dec.cls == cls_store),
		addr: (state == st_mem) ? data_addr : pc,
		wdata: rs2_val
	};

	assign we = (state == st_write) && dec.writes_rd;
	assign rd = dec.rd;

	always_comb begin
		case (dec.cls)
			cls_lui: rd_val = dec.imm;
			cls_auipc: rd_val = pc_target;
			cls_alu: rd_val = alu_result;
			cls_load: rd_val = rdata; // held by the bus master since done
			cls_jal, cls_jalr: rd_val = pc_plus4;
			default: rd_val = '0;
		endcase
	end

	always_comb begin
		case (dec.cls)
			cls_jal: pc_next = pc_target;
			cls_jalr: pc_next = {data_addr[xlen-1:1], 1'b0};
			cls_branch: pc_next = taken ? pc_target : pc_plus4;
			default: pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch && done) begin
			instr <= rdata;
		end
	end

	always_ff @(posedge clk) begin
		start <= 1'b0;
		if (!rstn) begin
			state <= st_fetch;
			pc <= reset_pc;
			busy <= 1'b0;
		end else begin
			case (state)
				st_fetch: begin
					if (!busy) begin
						start <= 1'b1;
						busy <= 1'b1;
					end
					if (done) begin
						busy <= 1'b0;
						state <= st_decode;
					end
				end
				st_decode: state <= st_read;
				st_read: state <= st_exec;
				st_exec: state <= st_mem;
				st_mem: begin
					if (!is_mem) begin
						state <= st_write;
					end else begin
						if (!busy) begin
							start <= 1'b1;
							busy <= 1'b1;
						end
						if (done) begin
							busy <= 1'b0;
							state <= st_write;
						end
					end
				end
				default: begin
					pc <= pc_next;
					state <= st_fetch;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/bus_master.sv
`timescale 1ns/1ns
`default_nettype none

module bus_master (
	input wire clk,
	input wire rstn,
	input wire rv_pkg::bus_cmd_t cmd,
	input wire start,
	output logic done,
	output rv_pkg::word_t rdata,
	output rv_pkg::rd_req_t rd_req,
	input wire rv_pkg::rd_rsp_t rd_rsp,
	output rv_pkg::wr_req_t wr_req,
	input wire rv_pkg::wr_rsp_t wr_rsp
);
	import rv_pkg::*;

	typedef enum logic [2:0] {
		bs_idle,
		bs_ar,
		bs_r,
		bs_w,
		bs_b
	} bus_state_e;

	bus_state_e state;
	word_t addr_q; // shared by both channels
	word_t wdata_q;
	logic arvalid;
	logic rready;
	logic awvalid;
	logic wvalid;
	logic bready;

	assign rd_req = '{araddr: addr_q, arvalid: arvalid, rready: rready};
	assign wr_req = '{
		awaddr: addr_q,
		awvalid: awvalid,
		wdata: wdata_q,
		wvalid: wvalid,
		bready: bready
	};

	always_ff @(posedge clk) begin
		if (state == bs_idle && start) begin
			addr_q <= {cmd.addr[xlen-1:2], 2'b00};
			wdata_q <= cmd.wdata;
		end
		if (state == bs_r && rd_rsp.rvalid) begin
			rdata <= rd_rsp.rdata;
		end
	end

	always_ff @(posedge clk) begin
		done <= 1'b0;
		if (!rstn) begin
			state <= bs_idle;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
		end else begin
			case (state)
				bs_idle: begin
					if (start && cmd.is_write) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						state <= bs_w;
					end else if (start) begin
						arvalid <= 1'b1;
						state <= bs_ar;
					end
				end
				bs_ar: begin
					if (rd_rsp.arready) begin
						arvalid <= 1'b0;
						rready <= 1'b1;
						state <= bs_r;
					end
				end
				bs_r: begin
					if (rd_rsp.rvalid) begin
						rready <= 1'b0;
						done <= 1'b1;
						state <= bs_idle;
					end
				end
				bs_w: begin
					if (wr_rsp.awready) awvalid <= 1'b0;
					if (wr_rsp.wready) wvalid <= 1'b0;
					if (!awvalid && !wvalid) begin // both accepted
						bready <= 1'b1;
						state <= bs_b;
					end
				end
				default: begin
					if (wr_rsp.bvalid) begin
						bready <= 1'b0;
						done <= 1'b1;
						state <= bs_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input wire clk,
	input wire rstn,
	output rv_pkg::rd_req_t rd_req,
	input wire rv_pkg::rd_rsp_t rd_rsp,
	output rv_pkg::wr_req_t wr_req,
	input wire rv_pkg::wr_rsp_t wr_rsp
);
	import rv_pkg::*;

	word_t instr;
	decoded_t dec;
	word_t rs1_val;
	word_t rs2_val;
	word_t alu_result;
	logic taken;
	bus_cmd_t cmd;
	logic start;
	logic done;
	word_t rdata;
	logic we;
	reg_idx_t rd;
	word_t rd_val;

	instr_decoder u_decoder (
		.clk(clk), .rstn(rstn), .instr(instr), .dec(dec)
	);

	int_regfile u_regfile (
		.clk(clk), .rstn(rstn),
		.rs1(dec.rs1), .rs2(dec.rs2), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.we(we), .rd(rd), .rd_val(rd_val)
	);

	int_alu u_alu (
		.clk(clk), .rstn(rstn), .dec(dec),
		.rs1_val(rs1_val), .rs2_val(rs2_val), .result(alu_result), .taken(taken)
	);

	core_control #(.reset_pc(reset_pc)) u_control (
		.clk(clk), .rstn(rstn), .instr(instr), .dec(dec),
		.rs1_val(rs1_val), .rs2_val(rs2_val), .alu_result(alu_result), .taken(taken),
		.cmd(cmd), .start(start), .done(done), .rdata(rdata),
		.we(we), .rd(rd), .rd_val(rd_val)
	);

	bus_master u_bus (
		.clk(clk), .rstn(rstn), .cmd(cmd), .start(start), .done(done), .rdata(rdata),
		.rd_req(rd_req), .rd_rsp(rd_rsp), .wr_req(wr_req), .wr_rsp(wr_rsp)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
	parameter int half_period = 2
) (
	output logic clk
);
	initial clk = 1'b0;

	always #(half_period) clk = ~clk;

endmodule

`default_nettype wire

// File: testbench/tb_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core;
	import rv_pkg::*;

	localparam word_t start_pc = 32'h0000_0040;
	localparam int worst_instr_cycles = 30; // 6 states plus two slow transfers

	logic clk;
	logic rstn;
	rd_req_t rd_req;
	rd_rsp_t rd_rsp;
	wr_req_t wr_req;
	wr_rsp_t wr_rsp;

	word_t mem [0:255];
	word_t ref_mem [0:255];
	word_t exp_reads [$];
	word_t exp_wr_addr [$];
	word_t exp_wr_data [$];
	word_t loop_pc;
	word_t asm_pc;
	word_t read_addr;
	word_t wr_addr_q;
	word_t wr_data_q;
	int n_exec;
	int mismatch_count;
	int protocol_count;
	int write_count;
	int ar_wait;
	int r_wait;
	int aw_wait;
	int w_wait;
	int b_wait;
	logic ref_done;
	logic reached_end;
	logic rstn_d;
	logic outstanding;
	rd_req_t prev_rd;
	rd_rsp_t prev_rd_rsp;
	wr_req_t prev_wr;
	wr_rsp_t prev_wr_rsp;

	tb_clock u_clock (.clk(clk));

	rv_core #(.reset_pc(start_pc)) DUT (
		.clk(clk), .rstn(rstn),
		.rd_req(rd_req), .rd_rsp(rd_rsp), .wr_req(wr_req), .wr_rsp(wr_rsp)
	);

	task automatic report_mismatch(input string name, input word_t exp, input word_t act);
		mismatch_count++;
		$display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
	endtask

	task automatic report_violation(input string what);
		protocol_count++;
		$display("protocol error at %0t ns: %s", $time, what);
	endtask

	function automatic word_t r_enc(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic word_t i_enc(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t s_enc(input logic [11:0] imm, input logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23}; // base is always x0
	endfunction

	function automatic word_t b_enc(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic word_t j_enc(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	task automatic emit(input word_t w);
		mem[asm_pc[9:2]] = w;
		asm_pc += 4;
	endtask

	task automatic load_program();
		logic [11:0] st;
		logic [11:0] imm;
		logic [2:0] conds [6];
		for (int i = 0; i < 256; i++) mem[i] = (i * 32'h0100_0193) ^ 32'ha5a5_0000;
		conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		asm_pc = start_pc;
		st = 12'h200;
		emit({20'h12345, 5'd1, 7'h37});
		emit(i_enc(12'h678, 1, 0, 1, 7'h13));
		emit(i_enc(12'hffb, 0, 0, 2, 7'h13)); // x2 = -5
		emit(i_enc(12'h003, 0, 0, 3, 7'h13));
		for (int f = 0; f < 8; f++) begin
			emit(r_enc(7'h00, 2, 1, f, 5));
			emit(s_enc(st, 5));
			st += 4;
			if (f == 0 || f == 5) begin
				emit(r_enc(7'h20, 2, 1, f, 5));
				emit(s_enc(st, 5));
				st += 4;
			end
		end
		for (int f = 0; f < 8; f++) begin
			imm = (f == 1 || f == 5) ? 12'h007 : 12'h8f3;
			emit(i_enc(imm, 1, f, 5, 7'h13));
			emit(s_enc(st, 5));
			st += 4;
			if (f == 5) begin
				emit(i_enc(12'h407, 1, f, 5, 7'h13)); // srai
				emit(s_enc(st, 5));
				st += 4;
			end
		end
		emit({20'h00001, 5'd6, 7'h17});
		emit(s_enc(st, 6));
		st += 4;
		emit(i_enc(12'h005, 1, 0, 0, 7'h13)); // write to x0
		emit(s_enc(st, 0));
		st += 4;
		for (int c = 0; c < 6; c++) begin
			emit(b_enc(13'd8, 3, 2, conds[c]));
			emit(i_enc(12'h001, 7, 0, 7, 7'h13));
			emit(b_enc(13'd8, 2, 3, conds[c]));
			emit(i_enc(12'h002, 7, 0, 7, 7'h13));
			emit(b_enc(13'd8, 3, 3, conds[c]));
			emit(i_enc(12'h004, 7, 0, 7, 7'h13));
		end
		emit(s_enc(st, 7));
		st += 4;
		emit(j_enc(21'd8, 8));
		emit(i_enc(12'h064, 7, 0, 7, 7'h13));
		emit(s_enc(st, 8));
		st += 4;
		emit(i_enc(asm_pc[11:0] + 12'd13, 0, 0, 9, 7'h13)); // odd target with bit 0 dropped
		emit(i_enc(12'h000, 9, 0, 10, 7'h67));
		emit(i_enc(12'h064, 7, 0, 7, 7'h13));
		emit(s_enc(st, 10));
		st += 4;
		emit(s_enc(st, 7));
		emit(s_enc(12'h303, 1));
		emit(i_enc(12'h302, 0, 3'b010, 11, 7'h03));
		emit(s_enc(12'h304, 11));
		emit(32'hffff_ffff); // unknown opcode runs as a no-op
		emit(j_enc(21'd0, 0));
		for (int i = 0; i < 256; i++) ref_mem[i] = mem[i];
	endtask

	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
		input word_t a, input word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// instruction-level model giving the expected read and write sequences
	task automatic run_reference();
		word_t x [32];
		word_t pc;
		word_t nxt;
		word_t w;
		word_t ii;
		word_t is;
		word_t ib;
		word_t ij;
		word_t addr;
		word_t res;
		logic [2:0] f3;
		logic tk;
		pc = start_pc;
		for (int i = 0; i < 32; i++) x[i] = '0;
		n_exec = 0;
		while (n_exec < 2000) begin
			w = ref_mem[pc[9:2]];
			exp_reads.push_back(pc);
			n_exec++;
			if (w == j_enc(21'd0, 0)) break;
			f3 = w[14:12];
			ii = {{20{w[31]}}, w[31:20]};
			is = {{20{w[31]}}, w[31:25], w[11:7]};
			ib = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			ij = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			nxt = pc + 4;
			res = '0;
			case (w[6:0])
				7'h37: res = {w[31:12], 12'd0};
				7'h17: res = pc + {w[31:12], 12'd0};
				7'h13: res = alu_ref(f3, (f3 == 3'd5) && w[30], x[w[19:15]], ii);
				7'h33: res = alu_ref(f3, w[30], x[w[19:15]], x[w[24:20]]);
				7'h6f: begin
					res = pc + 4;
					nxt = pc + ij;
				end
				7'h67: begin
					res = pc + 4;
					nxt = (x[w[19:15]] + ii) & ~32'd1;
				end
				7'h63: begin
					case (f3)
						3'd0: tk = x[w[19:15]] == x[w[24:20]];
						3'd1: tk = x[w[19:15]] != x[w[24:20]];
						3'd4: tk = $signed(x[w[19:15]]) < $signed(x[w[24:20]]);
						3'd5: tk = $signed(x[w[19:15]]) >= $signed(x[w[24:20]]);
						3'd6: tk = x[w[19:15]] < x[w[24:20]];
						default: tk = x[w[19:15]] >= x[w[24:20]];
					endcase
					if (tk) nxt = pc + ib;
				end
				7'h03: begin
					addr = (x[w[19:15]] + ii) & ~32'd3;
					exp_reads.push_back(addr);
					res = ref_mem[addr[9:2]];
				end
				7'h23: begin
					addr = (x[w[19:15]] + is) & ~32'd3;
					ref_mem[addr[9:2]] = x[w[24:20]];
					exp_wr_addr.push_back(addr);
					exp_wr_data.push_back(x[w[24:20]]);
				end
				default: ;
			endcase
			if (w[6:0] inside {7'h37, 7'h17, 7'h13, 7'h33, 7'h6f, 7'h67, 7'h03} && w[11:7] != 0)
				x[w[11:7]] = res;
			pc = nxt;
		end
		loop_pc = pc;
	endtask

	// memory model responses, each ready or valid held one cycle
	always @(negedge clk) begin
		if (!rstn) begin
			rd_rsp = '0;
			wr_rsp = '0;
		end else begin
			if (rd_rsp.arready) begin
				rd_rsp.arready = 1'b0;
				ar_wait = $urandom % 4;
			end else if (rd_req.arvalid) begin
				if (ar_wait == 0) rd_rsp.arready = 1'b1;
				else ar_wait--;
			end
			if (rd_rsp.rvalid) begin
				rd_rsp.rvalid = 1'b0;
				r_wait = $urandom % 4;
			end else if (rd_req.rready) begin
				if (r_wait == 0) begin
					rd_rsp.rvalid = 1'b1;
					rd_rsp.rdata = mem[read_addr[9:2]];
				end else begin
					r_wait--;
				end
			end
			if (wr_rsp.awready) begin
				wr_rsp.awready = 1'b0;
				aw_wait = $urandom % 4;
			end else if (wr_req.awvalid) begin
				if (aw_wait == 0) wr_rsp.awready = 1'b1;
				else aw_wait--;
			end
			if (wr_rsp.wready) begin
				wr_rsp.wready = 1'b0;
				w_wait = $urandom % 4;
			end else if (wr_req.wvalid) begin
				if (w_wait == 0) wr_rsp.wready = 1'b1;
				else w_wait--;
			end
			if (wr_rsp.bvalid) begin
				wr_rsp.bvalid = 1'b0;
				b_wait = $urandom % 4;
			end else if (wr_req.bready) begin
				if (b_wait == 0) wr_rsp.bvalid = 1'b1;
				else b_wait--;
			end
		end
	end

	always @(posedge clk) begin
		word_t exp;
		if (!rstn_d) begin
			assert (!rd_req.arvalid && !rd_req.rready && !wr_req.awvalid && !wr_req.wvalid
				&& !wr_req.bready) else report_violation("bus valid or ready high in reset");
		end else if (rstn) begin
			if (prev_rd.arvalid && !prev_rd_rsp.arready)
				assert (rd_req.arvalid && rd_req.araddr == prev_rd.araddr)
					else report_violation("arvalid or araddr changed before arready");
			if (prev_wr.awvalid && !prev_wr_rsp.awready)
				assert (wr_req.awvalid && wr_req.awaddr == prev_wr.awaddr)
					else report_violation("awvalid or awaddr changed before awready");
			if (prev_wr.wvalid && !prev_wr_rsp.wready)
				assert (wr_req.wvalid && wr_req.wdata == prev_wr.wdata)
					else report_violation("wvalid or wdata changed before wready");
			assert (!(rd_req.arvalid && rd_req.rready))
				else report_violation("rready high together with arvalid");
			if ((rd_req.arvalid && !prev_rd.arvalid) || (wr_req.awvalid && !prev_wr.awvalid)) begin
				assert (!outstanding) else report_violation("new request while one is outstanding");
				outstanding = 1'b1;
			end
			if (rd_req.arvalid && rd_rsp.arready) begin
				read_addr = rd_req.araddr;
				exp = (exp_reads.size() > 0) ? exp_reads.pop_front() : loop_pc;
				assert (rd_req.araddr == exp) else report_mismatch("araddr", exp, rd_req.araddr);
				if (exp_reads.size() == 0) reached_end = 1'b1;
			end
			if (rd_req.rready && rd_rsp.rvalid) outstanding = 1'b0;
			if (wr_req.awvalid && wr_rsp.awready) wr_addr_q = wr_req.awaddr;
			if (wr_req.wvalid && wr_rsp.wready) wr_data_q = wr_req.wdata;
			if (wr_req.bready && wr_rsp.bvalid) begin
				outstanding = 1'b0;
				mem[wr_addr_q[9:2]] = wr_data_q;
				write_count++;
				if (exp_wr_addr.size() == 0) begin
					report_violation("write beyond the expected sequence");
				end else begin
					exp = exp_wr_addr.pop_front();
					assert (wr_addr_q == exp) else report_mismatch("awaddr", exp, wr_addr_q);
					exp = exp_wr_data.pop_front();
					assert (wr_data_q == exp) else report_mismatch("wdata", exp, wr_data_q);
				end
			end
		end
		rstn_d = rstn;
		prev_rd = rd_req;
		prev_rd_rsp = rd_rsp;
		prev_wr = wr_req;
		prev_wr_rsp = wr_rsp;
	end

	initial begin
		void'($urandom(16592));
		rstn = 1'b0;
		rd_rsp = '0;
		wr_rsp = '0;
		rstn_d = 1'b1;
		outstanding = 1'b0;
		reached_end = 1'b0;
		ref_done = 1'b0;
		mismatch_count = 0;
		protocol_count = 0;
		write_count = 0;
		ar_wait = 0;
		r_wait = 0;
		aw_wait = 0;
		w_wait = 0;
		b_wait = 0;
		load_program();
		run_reference();
		ref_done = 1'b1;
		repeat (10) @(negedge clk);
		rstn = 1'b1;
		wait (reached_end);
		repeat (40) @(negedge clk);
		assert (exp_wr_addr.size() == 0) else report_violation("expected writes never happened");
		$display("errors: %0d mismatches, %0d protocol, %0d writes logged",
			mismatch_count, protocol_count, write_count);
		if (mismatch_count == 0 && protocol_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (ref_done);
		#(longint'(n_exec) * 20 * worst_instr_cycles * 4);
		$display("timeout: the program never reached its final loop");
		$display("errors: %0d mismatches, %0d protocol, %0d writes logged",
			mismatch_count, protocol_count, write_count);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
src/rv_pkg.sv
src/instr_decoder.sv
src/int_regfile.sv
src/int_alu.sv
src/core_control.sv
src/bus_master.sv
src/rv_core.sv
testbench/tb_clock.sv
testbench/tb_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/instr_decoder.sv
  - src/int_regfile.sv
  - src/int_alu.sv
  - src/core_control.sv
  - src/bus_master.sv
  - src/rv_core.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_core.sv
